// ==== common/noc_pkg.sv ====
//################################################
// mesh geometry, router port numbering and the flit format.
// shared by the routers, the neuron cores and the controller.
//################################################
package noc_pkg;

  localparam int MESH_DIM   = 2;
  localparam int NUM_NODES  = MESH_DIM * MESH_DIM;
  localparam int COORD_W    = 2;
  localparam int BOUNDARY_X = 2;
  localparam int BOUNDARY_Y = 0;
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int NUM_PORTS  = 5;
  localparam int PORT_W     = 3;
  localparam int AXON_W     = 2;
  localparam int WEIGHT_W   = 6;

  // north is the row with the smaller y.
  typedef enum logic [PORT_W-1:0] {
    PORT_LOCAL,
    PORT_NORTH,
    PORT_SOUTH,
    PORT_EAST,
    PORT_WEST
  } port_e;

  typedef struct packed {
    logic [COORD_W-1:0]         dest_x;
    logic [COORD_W-1:0]         dest_y;
    logic [COORD_W-1:0]         src_x;
    logic [COORD_W-1:0]         src_y;
    logic [AXON_W-1:0]          axon;
    logic signed [WEIGHT_W-1:0] weight;
  } flit_t;

endpackage

// ==== common/spike_pkg.sv ====
//################################################
// neuron constants, the host command word and the returned spike record.
//################################################
package spike_pkg;

  localparam int NUM_NURNS = 4;
  localparam int NURN_W    = $clog2(NUM_NURNS);
  localparam int POT_W     = 10;
  localparam int THRESHOLD = 32;
  localparam int HOST_W    = 32;
  localparam int STEP_W    = 16;

  // kind is bit 31 in both views. 0 is a spike, 1 a step command.
  typedef union packed {
    struct packed {
      logic                                kind;
      logic [noc_pkg::COORD_W-1:0]         dest_x;
      logic [noc_pkg::COORD_W-1:0]         dest_y;
      logic [noc_pkg::AXON_W-1:0]          axon;
      logic signed [noc_pkg::WEIGHT_W-1:0] weight;
      logic [18:0]                         pad;
    } spike_cmd;
    struct packed {
      logic                     kind;
      logic [HOST_W-STEP_W-2:0] pad;
      logic [STEP_W-1:0]        steps;
    } step_cmd;
  } host_word_u;

  typedef struct packed {
    logic [noc_pkg::COORD_W-1:0] src_x;
    logic [noc_pkg::COORD_W-1:0] src_y;
    logic [NURN_W-1:0]           neuron;
  } out_spike_t;

endpackage

// ==== router/spike_fifo.sv ====
//################################################
// flit buffer for one router input or the host queue.
// the head word is visible while empty is low.
//################################################
`timescale 1ns/1ps

module spike_fifo (
  input  logic           neu_clk,
  input  logic           reset,
  input  logic           push,
  input  noc_pkg::flit_t din,
  input  logic           pop,
  output noc_pkg::flit_t dout,
  output logic           empty,
  output logic           almost_full
);

  noc_pkg::flit_t             mem [noc_pkg::FIFO_DEPTH];
  logic [noc_pkg::PTR_W-1:0]  wr_ptr;
  logic [noc_pkg::PTR_W-1:0]  rd_ptr;
  logic [noc_pkg::PTR_W:0]    count;

  always_ff @(posedge neu_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + noc_pkg::PTR_W'(push);
      rd_ptr <= rd_ptr + noc_pkg::PTR_W'(pop);
      count  <= count + (noc_pkg::PTR_W+1)'(push) - (noc_pkg::PTR_W+1)'(pop);
    end
  end

  always_ff @(posedge neu_clk) begin
    if (push) mem[wr_ptr] <= din;
  end

  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  // one slot of margin for the sender's registered write request.
  assign almost_full = (count >= noc_pkg::FIFO_DEPTH - 1);

  a_no_overflow: assert property (@(posedge neu_clk) disable iff (reset)
    push |-> count < noc_pkg::FIFO_DEPTH);
  a_no_underflow: assert property (@(posedge neu_clk) disable iff (reset)
    pop |-> !empty);

endmodule

// ==== router/router.sv ====
//################################################
// five-port mesh router with input FIFOs and a registered output per port.
// each output serves its requesting inputs in round-robin order.
//################################################
`timescale 1ns/1ps

module router (
  input  logic                          neu_clk,
  input  logic                          reset,
  input  logic [noc_pkg::COORD_W-1:0]   my_x,
  input  logic [noc_pkg::COORD_W-1:0]   my_y,
  input  noc_pkg::flit_t                in_data [noc_pkg::NUM_PORTS],
  input  logic [noc_pkg::NUM_PORTS-1:0] in_write,
  input  logic [noc_pkg::NUM_PORTS-1:0] out_full,
  output logic [noc_pkg::NUM_PORTS-1:0] in_full,
  output noc_pkg::flit_t                out_data [noc_pkg::NUM_PORTS],
  output logic [noc_pkg::NUM_PORTS-1:0] out_write,
  output logic                          idle
);

  noc_pkg::flit_t                head   [noc_pkg::NUM_PORTS];
  noc_pkg::port_e                route  [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] grant  [noc_pkg::NUM_PORTS];
  logic [noc_pkg::PORT_W-1:0]    sel    [noc_pkg::NUM_PORTS];
  logic [noc_pkg::PORT_W-1:0]    rr_ptr [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] empty;
  logic [noc_pkg::NUM_PORTS-1:0] pop;

  // dimension order, x before y. Traffic bound for the boundary column
  // settles its row first, since only row 0 has a link out of the east edge.
  function automatic noc_pkg::port_e next_port(input noc_pkg::flit_t f);
    if (f.dest_x == my_x && f.dest_y == my_y) return noc_pkg::PORT_LOCAL;
    if (f.dest_x == noc_pkg::BOUNDARY_X && f.dest_y != my_y)
      return (f.dest_y < my_y) ? noc_pkg::PORT_NORTH : noc_pkg::PORT_SOUTH;
    if (f.dest_x > my_x) return noc_pkg::PORT_EAST;
    if (f.dest_x < my_x) return noc_pkg::PORT_WEST;
    return (f.dest_y < my_y) ? noc_pkg::PORT_NORTH : noc_pkg::PORT_SOUTH;
  endfunction

  for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_port
    spike_fifo i_fifo (
      .neu_clk     (neu_clk),
      .reset       (reset),
      .push        (in_write[p]),
      .din         (in_data[p]),
      .pop         (pop[p]),
      .dout        (head[p]),
      .empty       (empty[p]),
      .almost_full (in_full[p])
    );

    assign route[p] = next_port(head[p]);

    // a flit never leaves through the port it came in on.
    a_no_u_turn: assert property (@(posedge neu_clk) disable iff (reset)
      !empty[p] |-> route[p] != noc_pkg::port_e'(p));
  end

  always_comb begin
    logic [noc_pkg::PORT_W-1:0] idx;
    pop = '0;
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      grant[o] = '0;
      sel[o]   = '0;
      // search starts one past the input served last.
      for (int k = 1; k <= noc_pkg::NUM_PORTS; k++) begin
        idx = noc_pkg::PORT_W'((int'(rr_ptr[o]) + k) % noc_pkg::NUM_PORTS);
        if (!out_full[o] && grant[o] == '0 && !empty[idx] &&
            route[idx] == noc_pkg::port_e'(o)) begin
          grant[o][idx] = 1'b1;
          sel[o]        = idx;
        end
      end
      pop = pop | grant[o];
    end
  end

  always_ff @(posedge neu_clk) begin
    if (reset) begin
      out_write <= '0;
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) rr_ptr[o] <= '0;
    end else begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        out_write[o] <= |grant[o];
        if (|grant[o]) rr_ptr[o] <= sel[o];
      end
    end
  end

  always_ff @(posedge neu_clk) begin
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      if (|grant[o]) out_data[o] <= head[sel[o]];
    end
  end

  assign idle = (&empty) && (out_write == '0);

endmodule

// ==== mesh/neuron_core.sv ====
//################################################
// integrate-and-fire core on a router's local port.
// fires on step_tick and reports each spike to the boundary router.
//################################################
`timescale 1ns/1ps

module neuron_core (
  input  logic                        neu_clk,
  input  logic                        reset,
  input  logic [noc_pkg::COORD_W-1:0] my_x,
  input  logic [noc_pkg::COORD_W-1:0] my_y,
  input  logic                        step_tick,
  input  noc_pkg::flit_t              in_data,
  input  logic                        in_write,
  input  logic                        out_full,
  output logic                        in_full,
  output noc_pkg::flit_t              out_data,
  output logic                        out_write,
  output logic                        idle
);

  logic signed [spike_pkg::POT_W-1:0] pot [spike_pkg::NUM_NURNS];
  logic [spike_pkg::NUM_NURNS-1:0]    fire_now;
  logic [spike_pkg::NUM_NURNS-1:0]    fire_mask;
  logic [spike_pkg::NURN_W-1:0]       next_idx;

  // clamps at the rails instead of wrapping.
  function automatic logic signed [spike_pkg::POT_W-1:0] sat_add(
    input logic signed [spike_pkg::POT_W-1:0]    a,
    input logic signed [noc_pkg::WEIGHT_W-1:0]   w
  );
    logic signed [spike_pkg::POT_W:0] sum;
    sum = a + w;
    if (sum[spike_pkg::POT_W] != sum[spike_pkg::POT_W-1])
      return {sum[spike_pkg::POT_W], {(spike_pkg::POT_W-1){~sum[spike_pkg::POT_W]}}};
    return sum[spike_pkg::POT_W-1:0];
  endfunction

  always_comb begin
    next_idx = '0;
    for (int i = spike_pkg::NUM_NURNS - 1; i >= 0; i--) begin
      fire_now[i] = (pot[i] >= spike_pkg::THRESHOLD);
      if (fire_mask[i]) next_idx = spike_pkg::NURN_W'(i);
    end
  end

  always_ff @(posedge neu_clk) begin
    if (reset) begin
      for (int i = 0; i < spike_pkg::NUM_NURNS; i++) pot[i] <= '0;
      fire_mask <= '0;
      out_write <= 1'b0;
    end else begin
      for (int i = 0; i < spike_pkg::NUM_NURNS; i++) begin
        if (step_tick && fire_now[i]) pot[i] <= '0;
        else if (in_write && in_data.axon == i) pot[i] <= sat_add(pot[i], in_data.weight);
      end
      out_write <= 1'b0;
      if (step_tick) begin
        fire_mask <= fire_now;
      end else if (fire_mask != '0 && !out_full) begin
        fire_mask[next_idx] <= 1'b0;
        out_write           <= 1'b1;
      end
    end
  end

  always_ff @(posedge neu_clk) begin
    out_data.dest_x <= noc_pkg::COORD_W'(noc_pkg::BOUNDARY_X);
    out_data.dest_y <= noc_pkg::COORD_W'(noc_pkg::BOUNDARY_Y);
    out_data.src_x  <= my_x;
    out_data.src_y  <= my_y;
    out_data.axon   <= next_idx;
    out_data.weight <= '0;
  end

  assign in_full = 1'b0;
  assign idle    = (fire_mask == '0) && !out_write;

  // the controller holds the tick until the whole network has drained.
  a_tick_drained: assert property (@(posedge neu_clk) disable iff (reset)
    step_tick |-> fire_mask == '0);

endmodule

// ==== mesh/mesh_ap.sv ====
//################################################
// 2x2 grid of router and neuron core nodes.
// only node (1,0) has a link out, on its east port.
//################################################
`timescale 1ns/1ps

module mesh_ap (
  input  logic           neu_clk,
  input  logic           reset,
  input  logic           step_tick,
  input  noc_pkg::flit_t east_in,
  input  logic           east_write,
  input  logic           east_neighbor_full,
  output noc_pkg::flit_t east_out,
  output logic           east_out_write,
  output logic           east_full,
  output logic           idle
);

  // lin_* enter a router and lout_* leave it.
  wire noc_pkg::flit_t                lin_data   [noc_pkg::NUM_NODES][noc_pkg::NUM_PORTS];
  wire [noc_pkg::NUM_PORTS-1:0]       lin_write  [noc_pkg::NUM_NODES];
  wire [noc_pkg::NUM_PORTS-1:0]       lout_full  [noc_pkg::NUM_NODES];
  noc_pkg::flit_t                     lout_data  [noc_pkg::NUM_NODES][noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0]      lout_write [noc_pkg::NUM_NODES];
  logic [noc_pkg::NUM_PORTS-1:0]      lin_full   [noc_pkg::NUM_NODES];
  logic [noc_pkg::NUM_NODES-1:0]      node_idle;

  for (genvar y = 0; y < noc_pkg::MESH_DIM; y++) begin : g_row
    for (genvar x = 0; x < noc_pkg::MESH_DIM; x++) begin : g_col
      localparam int N = y * noc_pkg::MESH_DIM + x;
      logic rt_idle;
      logic core_idle;

      router i_router (
        .neu_clk   (neu_clk),
        .reset     (reset),
        .my_x      (noc_pkg::COORD_W'(x)),
        .my_y      (noc_pkg::COORD_W'(y)),
        .in_data   (lin_data[N]),
        .in_write  (lin_write[N]),
        .out_full  (lout_full[N]),
        .in_full   (lin_full[N]),
        .out_data  (lout_data[N]),
        .out_write (lout_write[N]),
        .idle      (rt_idle)
      );

      neuron_core i_core (
        .neu_clk   (neu_clk),
        .reset     (reset),
        .my_x      (noc_pkg::COORD_W'(x)),
        .my_y      (noc_pkg::COORD_W'(y)),
        .step_tick (step_tick),
        .in_data   (lout_data[N][noc_pkg::PORT_LOCAL]),
        .in_write  (lout_write[N][noc_pkg::PORT_LOCAL]),
        .out_full  (lin_full[N][noc_pkg::PORT_LOCAL]),
        .in_full   (lout_full[N][noc_pkg::PORT_LOCAL]),
        .out_data  (lin_data[N][noc_pkg::PORT_LOCAL]),
        .out_write (lin_write[N][noc_pkg::PORT_LOCAL]),
        .idle      (core_idle)
      );

      assign node_idle[N] = rt_idle && core_idle;

      for (genvar p = 1; p < noc_pkg::NUM_PORTS; p++) begin : g_dir
        localparam int NX  = x + int'(p == noc_pkg::PORT_EAST) - int'(p == noc_pkg::PORT_WEST);
        localparam int NY  = y + int'(p == noc_pkg::PORT_SOUTH) - int'(p == noc_pkg::PORT_NORTH);
        localparam int OPP = (p % 2 == 1) ? p + 1 : p - 1;

        if (NX >= 0 && NX < noc_pkg::MESH_DIM && NY >= 0 && NY < noc_pkg::MESH_DIM) begin : g_link
          assign lin_data[N][p]  = lout_data[NY * noc_pkg::MESH_DIM + NX][OPP];
          assign lin_write[N][p] = lout_write[NY * noc_pkg::MESH_DIM + NX][OPP];
          assign lout_full[N][p] = lin_full[NY * noc_pkg::MESH_DIM + NX][OPP];
        end else if (p == noc_pkg::PORT_EAST && y == noc_pkg::BOUNDARY_Y) begin : g_boundary
          assign lin_data[N][p]  = east_in;
          assign lin_write[N][p] = east_write;
          assign lout_full[N][p] = east_neighbor_full;
          assign east_out        = lout_data[N][p];
          assign east_out_write  = lout_write[N][p];
          assign east_full       = lin_full[N][p];
        end else begin : g_edge
          assign lin_data[N][p]  = '0;
          assign lin_write[N][p] = 1'b0;
          assign lout_full[N][p] = 1'b0;
        end
      end
    end
  end

  assign idle = &node_idle;

endmodule

// ==== logic/mesh_controller.sv ====
//################################################
// host side of the network. queues spike commands, paces time steps
// against the idle level and reports spikes coming back.
//################################################
`timescale 1ns/1ps

module mesh_controller (
  input  logic                          neu_clk,
  input  logic                          reset,
  input  logic                          host_write,
  input  spike_pkg::host_word_u         host_word,
  input  noc_pkg::flit_t                packet_in,
  input  logic                          packet_write,
  input  logic                          router_full,
  input  logic                          net_idle,
  output logic                          host_full,
  output noc_pkg::flit_t                spike_packet,
  output logic                          write_req,
  output logic                          step_tick,
  output logic [spike_pkg::STEP_W-1:0]  step_count,
  output logic                          busy,
  output logic                          out_valid,
  output spike_pkg::out_spike_t         out_spike
);

  noc_pkg::flit_t                host_flit;
  noc_pkg::flit_t                queue_head;
  logic                          queue_push;
  logic                          queue_pop;
  logic                          queue_empty;
  logic                          net_ready;
  logic                          ready_q;
  logic [spike_pkg::STEP_W-1:0]  steps_left;

  assign queue_push = host_write && !host_word.spike_cmd.kind && !host_full;
  assign queue_pop  = !queue_empty && !router_full;

  always_comb begin
    host_flit        = '0;
    host_flit.dest_x = host_word.spike_cmd.dest_x;
    host_flit.dest_y = host_word.spike_cmd.dest_y;
    host_flit.axon   = host_word.spike_cmd.axon;
    host_flit.weight = host_word.spike_cmd.weight;
  end

  spike_fifo i_queue (
    .neu_clk     (neu_clk),
    .reset       (reset),
    .push        (queue_push),
    .din         (host_flit),
    .pop         (queue_pop),
    .dout        (queue_head),
    .empty       (queue_empty),
    .almost_full (host_full)
  );

  // spikes still waiting here count as traffic too.
  assign net_ready = net_idle && queue_empty && !write_req;
  assign step_tick = (steps_left != '0) && net_ready && ready_q;
  assign busy      = (steps_left != '0);

  always_ff @(posedge neu_clk) begin
    if (reset) begin
      write_req  <= 1'b0;
      ready_q    <= 1'b0;
      steps_left <= '0;
      step_count <= '0;
      out_valid  <= 1'b0;
    end else begin
      write_req <= queue_pop;
      ready_q   <= net_ready && !step_tick;
      out_valid <= packet_write;
      if (host_write && host_word.step_cmd.kind) steps_left <= host_word.step_cmd.steps;
      else if (step_tick) steps_left <= steps_left - 1'b1;
      if (step_tick) step_count <= step_count + 1'b1;
    end
  end

  always_ff @(posedge neu_clk) begin
    spike_packet     <= queue_head;
    out_spike.src_x  <= packet_in.src_x;
    out_spike.src_y  <= packet_in.src_y;
    out_spike.neuron <= packet_in.axon;
  end

  // a second step command would overwrite the steps still pending.
  a_no_step_overlap: assert property (@(posedge neu_clk) disable iff (reset)
    host_write && host_word.step_cmd.kind |-> !busy);

endmodule

// ==== logic/mesh_with_controller.sv ====
//################################################
// top level. controller, boundary router at (2,0) and the 2x2 mesh.
//################################################
`timescale 1ns/1ps

module mesh_with_controller (
  input  logic                         neu_clk,
  input  logic                         reset,
  input  logic                         host_write,
  input  logic [spike_pkg::HOST_W-1:0] host_word,
  output logic                         host_full,
  output logic                         out_valid,
  output spike_pkg::out_spike_t        out_spike,
  output logic [spike_pkg::STEP_W-1:0] step_count,
  output logic                         busy
);

  noc_pkg::flit_t                c2b_data;
  noc_pkg::flit_t                m2b_data;
  noc_pkg::flit_t                b_out_data [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] b_out_write;
  logic [noc_pkg::NUM_PORTS-1:0] b_in_full;
  logic                          c2b_write;
  logic                          m2b_write;
  logic                          m_east_full;
  logic                          step_tick;
  logic                          mesh_idle;
  logic                          b_idle;

  mesh_controller i_ctrl (
    .neu_clk      (neu_clk),
    .reset        (reset),
    .host_write   (host_write),
    .host_word    (host_word),
    .packet_in    (b_out_data[noc_pkg::PORT_LOCAL]),
    .packet_write (b_out_write[noc_pkg::PORT_LOCAL]),
    .router_full  (b_in_full[noc_pkg::PORT_LOCAL]),
    .net_idle     (mesh_idle && b_idle),
    .host_full    (host_full),
    .spike_packet (c2b_data),
    .write_req    (c2b_write),
    .step_tick    (step_tick),
    .step_count   (step_count),
    .busy         (busy),
    .out_valid    (out_valid),
    .out_spike    (out_spike)
  );

  // port order is local, north, south, east, west.
  router i_boundary (
    .neu_clk   (neu_clk),
    .reset     (reset),
    .my_x      (noc_pkg::COORD_W'(noc_pkg::BOUNDARY_X)),
    .my_y      (noc_pkg::COORD_W'(noc_pkg::BOUNDARY_Y)),
    .in_data   ('{c2b_data, '0, '0, '0, m2b_data}),
    .in_write  ({m2b_write, 3'b000, c2b_write}),
    .out_full  ({m_east_full, 4'b0000}),
    .in_full   (b_in_full),
    .out_data  (b_out_data),
    .out_write (b_out_write),
    .idle      (b_idle)
  );

  mesh_ap i_mesh (
    .neu_clk            (neu_clk),
    .reset              (reset),
    .step_tick          (step_tick),
    .east_in            (b_out_data[noc_pkg::PORT_WEST]),
    .east_write         (b_out_write[noc_pkg::PORT_WEST]),
    .east_neighbor_full (b_in_full[noc_pkg::PORT_WEST]),
    .east_out           (m2b_data),
    .east_out_write     (m2b_write),
    .east_full          (m_east_full),
    .idle               (mesh_idle)
  );

endmodule

// ==== bench/tb_mesh.sv ====
//################################################
// testbench for the spike mesh top level. applies a table of host
// words row by row and checks returned spikes against a potential model.
//################################################
`timescale 1ns/1ps

module tb_mesh;

  localparam int TIMEOUT = 2000;

  logic                         neu_clk;
  logic                         reset;
  logic                         host_write;
  logic [spike_pkg::HOST_W-1:0] host_word;
  logic                         host_full;
  logic                         out_valid;
  spike_pkg::out_spike_t        out_spike;
  logic [spike_pkg::STEP_W-1:0] step_count;
  logic                         busy;

  logic [spike_pkg::HOST_W-1:0] stim_q [$];
  int                           row_len_q [$];
  int                           exp_num_q [$];
  logic [spike_pkg::STEP_W-1:0] exp_count_q [$];
  spike_pkg::out_spike_t        exp_spike_q [$];
  spike_pkg::out_spike_t        recv_q [$];
  int pot_model [noc_pkg::MESH_DIM][noc_pkg::MESH_DIM][spike_pkg::NUM_NURNS];
  int                           row_words;
  int                           step_total;
  logic [31:0]                  lfsr;

  mesh_with_controller i_dut (
    .neu_clk    (neu_clk),
    .reset      (reset),
    .host_write (host_write),
    .host_word  (host_word),
    .host_full  (host_full),
    .out_valid  (out_valid),
    .out_spike  (out_spike),
    .step_count (step_count),
    .busy       (busy)
  );

  initial begin
    neu_clk = 1'b0;
    forever #4 neu_clk = ~neu_clk;
  end

  // returned spikes are collected here and consumed row by row.
  always @(negedge neu_clk) begin
    if (!reset && out_valid === 1'b1) recv_q.push_back(out_spike);
  end

  task automatic stop_on_error();
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_spike(input spike_pkg::out_spike_t got, input spike_pkg::out_spike_t exp);
    if (got !== exp) begin
      $display("ERR out_spike got %h expected %h", got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input logic [spike_pkg::STEP_W-1:0] got,
                             input logic [spike_pkg::STEP_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken.
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int sat_pot(input int v);
    int hi;
    int lo;
    hi = (1 << (spike_pkg::POT_W - 1)) - 1;
    lo = -(1 << (spike_pkg::POT_W - 1));
    if (v > hi) return hi;
    if (v < lo) return lo;
    return v;
  endfunction

  task automatic add_spike(input int x, input int y, input int a, input int w);
    spike_pkg::host_word_u u;
    u                  = '0;
    u.spike_cmd.kind   = 1'b0;
    u.spike_cmd.dest_x = noc_pkg::COORD_W'(x);
    u.spike_cmd.dest_y = noc_pkg::COORD_W'(y);
    u.spike_cmd.axon   = noc_pkg::AXON_W'(a);
    u.spike_cmd.weight = noc_pkg::WEIGHT_W'(w);
    stim_q.push_back(u);
    row_words++;
    pot_model[x][y][a] = sat_pot(pot_model[x][y][a] + w);
  endtask

  // closes a row. every neuron at or above threshold fires and restarts at zero.
  task automatic add_steps(input int n);
    spike_pkg::host_word_u u;
    spike_pkg::out_spike_t s;
    int                    fired;
    u               = '0;
    u.step_cmd.kind  = 1'b1;
    u.step_cmd.steps = spike_pkg::STEP_W'(n);
    stim_q.push_back(u);
    row_len_q.push_back(row_words + 1);
    row_words  = 0;
    step_total = step_total + n;
    exp_count_q.push_back(spike_pkg::STEP_W'(step_total));
    fired = 0;
    for (int t = 0; t < n; t++) begin
      for (int x = 0; x < noc_pkg::MESH_DIM; x++) begin
        for (int y = 0; y < noc_pkg::MESH_DIM; y++) begin
          for (int a = 0; a < spike_pkg::NUM_NURNS; a++) begin
            if (pot_model[x][y][a] >= spike_pkg::THRESHOLD) begin
              s.src_x  = noc_pkg::COORD_W'(x);
              s.src_y  = noc_pkg::COORD_W'(y);
              s.neuron = spike_pkg::NURN_W'(a);
              exp_spike_q.push_back(s);
              pot_model[x][y][a] = 0;
              fired++;
            end
          end
        end
      end
    end
    exp_num_q.push_back(fired);
  endtask

  task automatic build_table();
    int x;
    int y;
    int a;
    int w;
    // threshold reached, then reached again from zero.
    add_spike(1, 1, 2, 20);
    add_spike(1, 1, 2, 12);
    add_steps(1);
    add_spike(1, 1, 2, 20);
    add_spike(1, 1, 2, 12);
    add_steps(1);
    // sub-threshold sums carry over, negative weights delay the fire.
    add_spike(0, 1, 1, 15);
    add_spike(1, 0, 3, 31);
    add_steps(1);
    add_spike(0, 1, 1, 15);
    add_spike(1, 0, 3, -20);
    add_steps(1);
    add_spike(0, 1, 1, -10);
    add_spike(0, 1, 1, 10);
    add_steps(1);
    add_spike(0, 1, 1, 2);
    add_spike(1, 0, 3, 21);
    add_steps(1);
    add_spike(0, 0, 3, 31);
    add_spike(0, 0, 3, 5);
    add_steps(5);
    // burst to every node and axon.
    for (int k = 0; k < 32; k++) begin
      add_spike(k % 2, (k / 2) % 2, (k / 4) % 4, (k < 16) ? 31 : 1);
    end
    add_steps(2);
    for (int r = 0; r < 6; r++) begin
      for (int k = 0; k < 12; k++) begin
        x = int'(draw_bits(1));
        y = int'(draw_bits(1));
        a = int'(draw_bits(2));
        w = int'(draw_bits(5)) - 8;
        add_spike(x, y, a, w);
      end
      add_steps(1 + int'(draw_bits(2)));
    end
  endtask

  task automatic write_word(input logic [spike_pkg::HOST_W-1:0] w);
    int cycles;
    cycles = 0;
    @(posedge neu_clk);
    #1;
    host_write = 1'b0;
    while (host_full) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout while host_full stayed high");
        stop_on_error();
      end
      @(posedge neu_clk);
      #1;
    end
    host_write = 1'b1;
    host_word  = w;
  endtask

  task automatic release_host();
    @(posedge neu_clk);
    #1;
    host_write = 1'b0;
  endtask

  task automatic wait_not_busy();
    int cycles;
    cycles = 0;
    while (busy !== 1'b0) begin
      @(negedge neu_clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout while busy stayed high");
        stop_on_error();
      end
    end
  endtask

  task automatic wait_spikes(input int num);
    int cycles;
    cycles = 0;
    while (recv_q.size() < num) begin
      @(negedge neu_clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout with %0d of %0d spikes returned", recv_q.size(), num);
        stop_on_error();
      end
    end
  endtask

  // order of arrival does not matter, each expected spike is taken once.
  task automatic match_spikes(input int first, input int num);
    spike_pkg::out_spike_t pending [$];
    spike_pkg::out_spike_t got;
    int                    hit;
    for (int i = 0; i < num; i++) pending.push_back(exp_spike_q[first + i]);
    for (int i = 0; i < num; i++) begin
      got = recv_q.pop_front();
      hit = -1;
      foreach (pending[j]) begin
        if (hit < 0 && pending[j] == got) hit = j;
      end
      if (hit < 0) check_spike(got, pending[0]);
      else pending.delete(hit);
    end
  endtask

  initial begin
    int w_idx;
    int e_idx;
    lfsr       = 32'h3aa9;
    row_words  = 0;
    step_total = 0;
    w_idx      = 0;
    e_idx      = 0;
    foreach (pot_model[x, y, a]) pot_model[x][y][a] = 0;
    reset      = 1'b1;
    host_write = 1'b0;
    host_word  = '0;
    build_table();
    repeat (3) @(posedge neu_clk);
    #1;
    reset = 1'b0;
    check_bit("host_full", host_full, 1'b0);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_count("step_count", step_count, '0);

    for (int row = 0; row < row_len_q.size(); row++) begin
      for (int k = 0; k < row_len_q[row]; k++) begin
        write_word(stim_q[w_idx]);
        w_idx++;
      end
      release_host();
      // the step command has just been taken.
      check_bit("busy", busy, 1'b1);
      wait_not_busy();
      wait_spikes(exp_num_q[row]);
      match_spikes(e_idx, exp_num_q[row]);
      e_idx = e_idx + exp_num_q[row];
      check_count("step_count", step_count, exp_count_q[row]);
    end

    // quiet window in which a late duplicate would still show up.
    repeat (100) @(negedge neu_clk);
    if (recv_q.size() != 0) begin
      $display("%0d spikes returned beyond the expected set", recv_q.size());
      stop_on_error();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== files.f ====
common/noc_pkg.sv
common/spike_pkg.sv
router/spike_fifo.sv
router/router.sv
mesh/neuron_core.sv
mesh/mesh_ap.sv
logic/mesh_controller.sv
logic/mesh_with_controller.sv
bench/tb_mesh.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mesh
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
